//--- filelist.f
rtl/rv_exec_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_exec_top.sv
tests/rv_exec_asserts.sv
tests/tb_rv_exec.sv

//--- run.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_rv_exec -f filelist.f -o sim_rv_exec

# the simulator status is not used, the pass line decides
out=$(./obj_dir/sim_rv_exec 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'SIMULATION PASSED'; then
   exit 0
else
   exit 1
fi

//--- tests/tb_rv_exec.sv
/*
 Random test of rv_exec_top against a RISC-V register model, fixed seed.
 The first 32 cycles only load the register file, instructions follow.
 */
module tb_rv_exec;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_HALF     = 4;
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int RESET_CYCLES = 2;
   localparam int NUM_CYCLES   = 2000;
   localparam int PRELOAD      = 32;
   localparam int WATCHDOG_NS  = (NUM_CYCLES + 20) * CLK_PERIOD;

   logic        i_clk;
   logic        i_rst;
   logic        i_valid;
   logic [31:0] i_inst;
   logic        i_wr_en;
   logic [4:0]  i_wr_addr;
   logic [31:0] i_wr_data;
   logic        o_valid;
   logic [31:0] o_result;
   logic [4:0]  o_rd;
   logic        o_illegal;

   // stimulus for the coming edge
   logic        nxt_valid;
   logic [31:0] nxt_inst;
   logic        nxt_wr_en;
   logic [4:0]  nxt_wr_addr;
   logic [31:0] nxt_wr_data;

   logic [31:0] model_regs [32];
   logic        exp_valid_q [$];
   logic        exp_ill_q [$];
   logic [4:0]  exp_rd_q [$];
   logic [31:0] exp_res_q [$];
   int          seed;
   int          cyc;

   rv_exec_top u_dut (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_valid   (i_valid),
      .i_inst    (i_inst),
      .i_wr_en   (i_wr_en),
      .i_wr_addr (i_wr_addr),
      .i_wr_data (i_wr_data),
      .o_valid   (o_valid),
      .o_result  (o_result),
      .o_rd      (o_rd),
      .o_illegal (o_illegal)
   );

   always #CLK_HALF i_clk = ~i_clk;

   function automatic logic inst_illegal(input logic [31:0] inst);
      logic [6:0] f7;
      logic [2:0] f3;
      logic       bad;
      f7  = inst[31:25];
      f3  = inst[14:12];
      bad = 1'b1;
      if (inst[6:0] == rv_exec_pkg::OPC_OP)
         bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      else if (inst[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
         if (f3 == 3'd1)
            bad = (f7 != 7'h00);
         else if (f3 == 3'd5)
            bad = !(f7 == 7'h00 || f7 == 7'h20);
         else
            bad = 1'b0;
      end else if (inst[6:0] == rv_exec_pkg::OPC_LUI)
         bad = 1'b0;
      return bad;
   endfunction

   // RV32I result for OP, OP-IMM and LUI
   function automatic logic [31:0] exec_inst(input logic [31:0] inst,
                                             input logic [31:0] a,
                                             input logic [31:0] rs2_val);
      logic [31:0] b;
      logic [31:0] res;
      logic [4:0]  sh;
      logic        alt;
      alt = inst[30];
      res = '0;
      if (inst[6:0] == rv_exec_pkg::OPC_LUI)
         return {inst[31:12], 12'b0};
      if (inst[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
         b   = {{20{inst[31]}}, inst[31:20]};
         alt = alt && (inst[14:12] == 3'd5);  // addi never subtracts
      end else
         b = rs2_val;
      sh = b[4:0];
      case (inst[14:12])
         3'd0: res = alt ? a - b : a + b;
         3'd1: res = a << sh;
         3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: res = (a < b) ? 32'd1 : 32'd0;
         3'd4: res = a ^ b;
         3'd5: begin
            if (alt)
               res = $signed(a) >>> sh;
            else
               res = a >> sh;
         end
         3'd6: res = a | b;
         default: res = a & b;
      endcase
      return res;
   endfunction

   function automatic logic [31:0] build_inst(input logic [3:0] kind, input logic [31:0] r);
      logic [6:0]  f7;
      logic [2:0]  f3;
      logic [31:0] w;
      f3 = r[14:12];
      f7 = r[31:25];
      if (kind <= 4'd5) begin
         f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
         w  = {f7, r[24:7], rv_exec_pkg::OPC_OP};
      end else if (kind <= 4'd11) begin
         if (f3 == 3'd1)
            f7 = 7'h00;
         else if (f3 == 3'd5)
            f7 = r[30] ? 7'h20 : 7'h00;
         w = {f7, r[24:7], rv_exec_pkg::OPC_OP_IMM};  // random imm, negatives too
      end else if (kind <= 4'd13)
         w = {r[31:7], rv_exec_pkg::OPC_LUI};
      else if (kind == 4'd14)
         w = r;  // almost always an unknown opcode
      else begin
         f7 = r[31:25] | 7'h02;  // neither 0x00 nor 0x20
         if (r[0])
            w = {f7, r[24:7], rv_exec_pkg::OPC_OP};
         else
            w = {f7, r[24:15], r[13] ? 3'd1 : 3'd5, r[11:7], rv_exec_pkg::OPC_OP_IMM};
      end
      return w;
   endfunction

   task automatic pick_preload(input logic [4:0] addr);
      nxt_valid   = 1'b0;
      nxt_inst    = $random(seed);  // junk while valid is low
      nxt_wr_en   = 1'b1;
      nxt_wr_addr = addr;
      nxt_wr_data = $random(seed);
   endtask

   task automatic pick_random();
      logic [31:0] r_ctl;
      logic [31:0] r_inst;
      r_ctl       = $random(seed);
      r_inst      = $random(seed);
      nxt_valid   = (r_ctl[1:0] != 2'b00);
      nxt_inst    = build_inst(r_ctl[5:2], r_inst);
      nxt_wr_en   = r_ctl[6];
      nxt_wr_data = $random(seed);
      if (r_ctl[7])
         nxt_wr_addr = r_ctl[8] ? nxt_inst[24:20] : nxt_inst[19:15];  // bypass case
      else
         nxt_wr_addr = r_ctl[13:9];
      // shared upper half, so compares reach the low half
      if (r_ctl[15:14] == 2'b00)
         nxt_wr_data[31:16] = model_regs[r_ctl[20:16]][31:16];
   endtask

   task automatic pick_idle();
      nxt_valid   = 1'b0;
      nxt_inst    = '0;
      nxt_wr_en   = 1'b0;
      nxt_wr_addr = '0;
      nxt_wr_data = '0;
   endtask

   task automatic apply_cycle();
      logic [31:0] a;
      logic [31:0] b;
      i_valid   <= nxt_valid;
      i_inst    <= nxt_inst;
      i_wr_en   <= nxt_wr_en;
      i_wr_addr <= nxt_wr_addr;
      i_wr_data <= nxt_wr_data;
      // a write on the same edge is seen by the instruction
      if (nxt_wr_en && nxt_wr_addr != 5'd0)
         model_regs[nxt_wr_addr] = nxt_wr_data;
      a = model_regs[nxt_inst[19:15]];
      b = model_regs[nxt_inst[24:20]];
      exp_valid_q.push_back(nxt_valid);
      exp_ill_q.push_back(nxt_valid && inst_illegal(nxt_inst));
      exp_rd_q.push_back(nxt_inst[11:7]);
      exp_res_q.push_back(exec_inst(nxt_inst, a, b));
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_outputs();
      logic        e_valid;
      logic        e_ill;
      logic [4:0]  e_rd;
      logic [31:0] e_res;
      if (exp_valid_q.size() > rv_exec_pkg::ALU_LATENCY) begin
         e_valid = exp_valid_q.pop_front();
         e_ill   = exp_ill_q.pop_front();
         e_rd    = exp_rd_q.pop_front();
         e_res   = exp_res_q.pop_front();
         check_value("o_valid", {31'b0, o_valid}, {31'b0, e_valid});
         check_value("o_illegal", {31'b0, o_illegal}, {31'b0, e_ill});
         if (e_valid)
            check_value("o_rd", {27'b0, o_rd}, {27'b0, e_rd});
         if (e_valid && !e_ill)
            check_value("o_result", o_result, e_res);
      end else
         check_value("o_valid", {31'b0, o_valid}, 32'd0);  // pipeline still empty
   endtask

   initial begin
      seed      = 32'h10b6_572b;
      i_clk     = 1'b0;
      i_rst     = 1'b1;
      i_valid   = 1'b0;
      i_inst    = '0;
      i_wr_en   = 1'b0;
      i_wr_addr = '0;
      i_wr_data = '0;
      for (int k = 0; k < 32; k++)
         model_regs[k] = '0;
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_rst <= 1'b0;
      for (cyc = 0; cyc < NUM_CYCLES + rv_exec_pkg::ALU_LATENCY; cyc++) begin
         @(posedge i_clk);
         if (cyc < PRELOAD)
            pick_preload(cyc[4:0]);
         else if (cyc < NUM_CYCLES)
            pick_random();
         else
            pick_idle();  // flush
         apply_cycle();
         @(negedge i_clk);
         check_outputs();
      end
      if (u_dut.u_asserts.fail_count == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("assertion failures seen: %0d", u_dut.u_asserts.fail_count);
         $display("SIMULATION FAILED");
         $fatal(1, "concurrent assertions failed");
      end
   end

   initial begin
      #WATCHDOG_NS;
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- tests/rv_exec_asserts.sv
/*
 Valid and illegal timing checks, bound into rv_exec_top.
 Data values are left to the testbench scoreboard.
 */
module rv_exec_asserts (
   input logic i_clk,
   input logic i_rst,
   input logic i_valid,
   input logic o_valid,
   input logic o_illegal
);
   timeunit 1ns;
   timeprecision 100ps;

   int cyc_since_rst;  // saturates at the pipeline depth
   int fail_count;     // read by the testbench at the end of the run

   always_ff @(posedge i_clk) begin
      if (i_rst)
         cyc_since_rst <= 0;
      else if (cyc_since_rst < rv_exec_pkg::ALU_LATENCY)
         cyc_since_rst <= cyc_since_rst + 1;
   end

   a_valid_latency: assert property (@(posedge i_clk) disable iff (i_rst)
      (cyc_since_rst == rv_exec_pkg::ALU_LATENCY)
         |-> (o_valid == $past(i_valid, rv_exec_pkg::ALU_LATENCY)))
      else begin
         fail_count = fail_count + 1;
         $error("o_valid does not follow i_valid by the pipeline latency");
      end

   a_illegal_has_valid: assert property (@(posedge i_clk) disable iff (i_rst)
      o_illegal |-> o_valid)
      else begin
         fail_count = fail_count + 1;
         $error("o_illegal set without o_valid");
      end

   // pipeline drained by reset
   a_quiet_after_reset: assert property (@(posedge i_clk) disable iff (i_rst)
      (cyc_since_rst < rv_exec_pkg::ALU_LATENCY) |-> !o_valid)
      else begin
         fail_count = fail_count + 1;
         $error("o_valid high right after reset");
      end

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_valid   (i_valid),
   .o_valid   (o_valid),
   .o_illegal (o_illegal)
);

//--- rtl/rv_exec_top.sv
/*
 Integer execute slice with result, rd and illegal flag 3 cycles after i_valid.
 Register writes come in on a separate port with no handshake.
 */
module rv_exec_top (
   input  logic                              i_clk,
   input  logic                              i_rst,
   input  logic                              i_valid,
   input  rv_exec_pkg::inst_word_u           i_inst,
   input  logic                              i_wr_en,
   input  logic [rv_exec_pkg::REG_AW-1:0]    i_wr_addr,
   input  logic [rv_exec_pkg::XLEN-1:0]      i_wr_data,
   output logic                              o_valid,
   output logic [rv_exec_pkg::XLEN-1:0]      o_result,
   output logic [rv_exec_pkg::REG_AW-1:0]    o_rd,
   output logic                              o_illegal
);

   // decoder to ALU
   logic                             dec_valid;
   logic [rv_exec_pkg::ALU_OP_W-1:0] dec_alu_op;
   logic [rv_exec_pkg::XLEN-1:0]     dec_imm;
   logic                             dec_use_imm;
   logic                             dec_zero_op1;
   logic [rv_exec_pkg::REG_AW-1:0]   dec_rd;
   logic                             dec_illegal;

   // register file to ALU
   logic [rv_exec_pkg::XLEN-1:0]     rs1_data;
   logic [rv_exec_pkg::XLEN-1:0]     rs2_data;

   rv_decoder u_decoder (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (i_valid),
      .i_inst     (i_inst),
      .o_valid    (dec_valid),
      .o_alu_op   (dec_alu_op),
      .o_imm      (dec_imm),
      .o_use_imm  (dec_use_imm),
      .o_zero_op1 (dec_zero_op1),
      .o_rd       (dec_rd),
      .o_illegal  (dec_illegal)
   );

   // read runs in parallel with decode, whatever the format
   rv_regfile u_regfile (
      .i_clk      (i_clk),
      .i_rs1_addr (i_inst.r_fmt.rs1),
      .i_rs2_addr (i_inst.r_fmt.rs2),
      .i_wr_en    (i_wr_en),
      .i_wr_addr  (i_wr_addr),
      .i_wr_data  (i_wr_data),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data)
   );

   rv_alu u_alu (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (dec_valid),
      .i_alu_op   (dec_alu_op),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .i_imm      (dec_imm),
      .i_use_imm  (dec_use_imm),
      .i_zero_op1 (dec_zero_op1),
      .i_rd       (dec_rd),
      .i_illegal  (dec_illegal),
      .o_valid    (o_valid),
      .o_result   (o_result),
      .o_rd       (o_rd),
      .o_illegal  (o_illegal)
   );

endmodule

//--- rtl/rv_alu.sv
/*
 Two-stage ALU. Shifts and unsigned compares are split on 16-bit halves and
 finished in the second stage. The result is meaningless when o_illegal is set.
 */
module rv_alu (
   input  logic                              i_clk,
   input  logic                              i_rst,
   input  logic                              i_valid,
   input  logic [rv_exec_pkg::ALU_OP_W-1:0]  i_alu_op,
   input  logic [rv_exec_pkg::XLEN-1:0]      i_rs1_data,
   input  logic [rv_exec_pkg::XLEN-1:0]      i_rs2_data,
   input  logic [rv_exec_pkg::XLEN-1:0]      i_imm,
   input  logic                              i_use_imm,
   input  logic                              i_zero_op1,
   input  logic [rv_exec_pkg::REG_AW-1:0]    i_rd,
   input  logic                              i_illegal,
   output logic                              o_valid,
   output logic [rv_exec_pkg::XLEN-1:0]      o_result,
   output logic [rv_exec_pkg::REG_AW-1:0]    o_rd,
   output logic                              o_illegal
);

   logic [rv_exec_pkg::XLEN-1:0]     op1;
   logic [rv_exec_pkg::XLEN-1:0]     op2;
   logic [rv_exec_pkg::XLEN-1:0]     add_res;
   logic [rv_exec_pkg::XLEN-1:0]     sub_res;
   logic                             slt;

   // stage 1
   logic [rv_exec_pkg::XLEN-1:0]     add_q, sub_q;
   logic [rv_exec_pkg::XLEN-1:0]     sll_q, srl_q, sra_q;
   logic [rv_exec_pkg::XLEN-1:0]     xor_q, or_q, and_q;
   logic                             sel16_q;
   logic                             slt_q;
   logic                             ltu_hi_q, eq_hi_q, ltu_lo_q;
   logic [rv_exec_pkg::ALU_OP_W-1:0] op_q;
   logic [rv_exec_pkg::REG_AW-1:0]   rd_q;
   logic                             valid_q;
   logic                             illegal_q;

   // stage 2 input
   logic [rv_exec_pkg::XLEN-1:0]     result_d;

   assign op1     = i_zero_op1 ? '0 : i_rs1_data;
   assign op2     = i_use_imm ? i_imm : i_rs2_data;
   assign add_res = op1 + op2;
   assign sub_res = op1 - op2;

   // sign of the difference, flipped on overflow
   assign slt = sub_res[rv_exec_pkg::XLEN-1]
                ^ ((op1[rv_exec_pkg::XLEN-1] ^ op2[rv_exec_pkg::XLEN-1])
                   & (sub_res[rv_exec_pkg::XLEN-1] ^ op1[rv_exec_pkg::XLEN-1]));

   always_ff @(posedge i_clk) begin
      add_q    <= add_res;
      sub_q    <= sub_res;
      sll_q    <= op1 << op2[3:0];
      srl_q    <= op1 >> op2[3:0];
      sra_q    <= $signed(op1) >>> op2[3:0];
      sel16_q  <= op2[4];                  // extra 16 places, applied later
      slt_q    <= slt;
      ltu_hi_q <= op1[16+:16] < op2[16+:16];
      eq_hi_q  <= op1[16+:16] == op2[16+:16];
      ltu_lo_q <= op1[0+:16] < op2[0+:16];
      xor_q    <= op1 ^ op2;
      or_q     <= op1 | op2;
      and_q    <= op1 & op2;
      op_q     <= i_alu_op;
      rd_q     <= i_rd;
   end

   always_comb begin
      case (op_q)
         rv_exec_pkg::ALUOP_ADD:  result_d = add_q;
         rv_exec_pkg::ALUOP_SUB:  result_d = sub_q;
         rv_exec_pkg::ALUOP_SLL:  result_d = sel16_q ? {sll_q[0+:16], 16'b0} : sll_q;
         rv_exec_pkg::ALUOP_SLT:  result_d = {31'b0, slt_q};
         rv_exec_pkg::ALUOP_SLTU: result_d = {31'b0, ltu_hi_q | (eq_hi_q & ltu_lo_q)};
         rv_exec_pkg::ALUOP_XOR:  result_d = xor_q;
         rv_exec_pkg::ALUOP_SRL:  result_d = sel16_q ? {16'b0, srl_q[16+:16]} : srl_q;
         rv_exec_pkg::ALUOP_SRA: begin
            result_d = sel16_q ? {{16{sra_q[31]}}, sra_q[16+:16]} : sra_q;
         end
         rv_exec_pkg::ALUOP_OR:   result_d = or_q;
         rv_exec_pkg::ALUOP_AND:  result_d = and_q;
         default:                 result_d = '0;  // illegal ops only
      endcase
   end

   always_ff @(posedge i_clk) begin
      o_result <= result_d;
      o_rd     <= rd_q;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         valid_q   <= 1'b0;
         illegal_q <= 1'b0;
         o_valid   <= 1'b0;
         o_illegal <= 1'b0;
      end else begin
         valid_q   <= i_valid;
         illegal_q <= i_illegal;
         o_valid   <= valid_q;
         o_illegal <= illegal_q;
      end
   end

endmodule

//--- rtl/rv_regfile.sv
/*
 32 x 32 register file, one write port, two registered read ports.
 A write on the same edge as a read is returned by that read. x0 is always zero.
 */
module rv_regfile (
   input  logic                              i_clk,
   input  logic [rv_exec_pkg::REG_AW-1:0]    i_rs1_addr,
   input  logic [rv_exec_pkg::REG_AW-1:0]    i_rs2_addr,
   input  logic                              i_wr_en,
   input  logic [rv_exec_pkg::REG_AW-1:0]    i_wr_addr,
   input  logic [rv_exec_pkg::XLEN-1:0]      i_wr_data,
   output logic [rv_exec_pkg::XLEN-1:0]      o_rs1_data,
   output logic [rv_exec_pkg::XLEN-1:0]      o_rs2_data
);

   logic [rv_exec_pkg::XLEN-1:0] regs [2**rv_exec_pkg::REG_AW];
   logic                         wr_ok;

   assign wr_ok = i_wr_en && (i_wr_addr != '0);  // x0 writes dropped

   // value seen by a read issued this cycle
   function automatic logic [rv_exec_pkg::XLEN-1:0] read_val(
      input logic [rv_exec_pkg::REG_AW-1:0] addr
   );
      logic [rv_exec_pkg::XLEN-1:0] val;
      if (addr == '0)
         val = '0;
      else if (wr_ok && (i_wr_addr == addr))
         val = i_wr_data;  // bypass
      else
         val = regs[addr];
      return val;
   endfunction

   always_ff @(posedge i_clk) begin
      if (wr_ok)
         regs[i_wr_addr] <= i_wr_data;
   end

   always_ff @(posedge i_clk) begin
      o_rs1_data <= read_val(i_rs1_addr);
      o_rs2_data <= read_val(i_rs2_addr);
   end

endmodule

//--- rtl/rv_decoder.sv
/*
 One-stage registered decoder for OP, OP-IMM and LUI only.
 Everything else, and any bad funct7 or shift encoding, comes out as illegal.
 */
module rv_decoder (
   input  logic                                i_clk,
   input  logic                                i_rst,
   input  logic                                i_valid,
   input  rv_exec_pkg::inst_word_u             i_inst,
   output logic                                o_valid,
   output logic [rv_exec_pkg::ALU_OP_W-1:0]    o_alu_op,
   output logic [rv_exec_pkg::XLEN-1:0]        o_imm,
   output logic                                o_use_imm,
   output logic                                o_zero_op1,
   output logic [rv_exec_pkg::REG_AW-1:0]      o_rd,
   output logic                                o_illegal
);

   logic [6:0]                          funct7;
   logic [2:0]                          funct3;
   logic [rv_exec_pkg::ALU_OP_W-1:0]    alu_op;
   logic [rv_exec_pkg::XLEN-1:0]        imm;
   logic                                use_imm;
   logic                                zero_op1;
   logic                                illegal;

   assign funct7 = i_inst.r_fmt.funct7;
   assign funct3 = i_inst.iu_fmt.funct3;

   always_comb begin
      alu_op   = {funct7[5], funct3};
      imm      = {{(rv_exec_pkg::XLEN-12){i_inst.iu_fmt.imm12[11]}}, i_inst.iu_fmt.imm12};
      use_imm  = 1'b0;
      zero_op1 = 1'b0;
      illegal  = 1'b0;
      case (i_inst.r_fmt.opcode)
         rv_exec_pkg::OPC_OP: begin
            // funct7 0x20 only exists for sub and sra
            if (funct7 == 7'h20)
               illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
            else
               illegal = (funct7 != 7'h00);
         end
         rv_exec_pkg::OPC_OP_IMM: begin
            use_imm = 1'b1;
            // imm bit 10 is only an op bit for srai, so addi never turns into sub
            alu_op  = {(funct3 == 3'b101) && funct7[5], funct3};
            if (funct3 == 3'b001)
               illegal = (funct7 != 7'h00);  // slli
            else if (funct3 == 3'b101)
               illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
         end
         rv_exec_pkg::OPC_LUI: begin
            use_imm  = 1'b1;
            zero_op1 = 1'b1;                 // 0 + U immediate
            alu_op   = rv_exec_pkg::ALUOP_ADD;
            imm      = {i_inst.iu_fmt.imm12, i_inst.iu_fmt.rs1, i_inst.iu_fmt.funct3, 12'b0};
         end
         default: illegal = 1'b1;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid   <= 1'b0;
         o_illegal <= 1'b0;
      end else begin
         o_valid   <= i_valid;
         o_illegal <= i_valid && illegal;  // only flagged on a real instruction
      end
   end

   always_ff @(posedge i_clk) begin
      o_alu_op   <= alu_op;
      o_imm      <= imm;
      o_use_imm  <= use_imm;
      o_zero_op1 <= zero_op1;
      o_rd       <= i_inst.r_fmt.rd;
   end

endmodule

//--- rtl/rv_exec_pkg.sv
/*
 Shared widths, opcodes and ALU op codes for the RV32I integer execute slice.
 ALU op codes are {funct7[5], funct3}. Only OP, OP-IMM and LUI are supported.
 */
package rv_exec_pkg;

   localparam int XLEN        = 32;
   localparam int REG_AW      = 5;
   localparam int ALU_OP_W    = 4;
   localparam int ALU_LATENCY = 3;  // i_valid to o_valid, in cycles

   // major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   localparam logic [ALU_OP_W-1:0] ALUOP_ADD  = 4'b0000;
   localparam logic [ALU_OP_W-1:0] ALUOP_SUB  = 4'b1000;
   localparam logic [ALU_OP_W-1:0] ALUOP_SLL  = 4'b0001;
   localparam logic [ALU_OP_W-1:0] ALUOP_SLT  = 4'b0010;
   localparam logic [ALU_OP_W-1:0] ALUOP_SLTU = 4'b0011;
   localparam logic [ALU_OP_W-1:0] ALUOP_XOR  = 4'b0100;
   localparam logic [ALU_OP_W-1:0] ALUOP_SRL  = 4'b0101;
   localparam logic [ALU_OP_W-1:0] ALUOP_SRA  = 4'b1101;
   localparam logic [ALU_OP_W-1:0] ALUOP_OR   = 4'b0110;
   localparam logic [ALU_OP_W-1:0] ALUOP_AND  = 4'b0111;

   // register-register layout
   typedef struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } r_fmt_t;

   // I layout, also carries the U immediate in imm12/rs1/funct3
   typedef struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } iu_fmt_t;

   typedef union packed {
      r_fmt_t  r_fmt;
      iu_fmt_t iu_fmt;
   } inst_word_u;

endpackage
